/* pat_pkg.sv */
package pat_pkg;

	localparam int d_width = 8;
	localparam int i_width = 20;
	localparam int i_adr_width = 10;
	localparam int port_count = 8;

	typedef logic [d_width-1:0] word_t;
	typedef logic [i_adr_width-1:0] iadr_t;

	// i8 space, 15 opens the i3 space
	typedef enum logic [3:0] {
		i8_or = 4'd0,
		i8_and = 4'd1,
		i8_addm = 4'd2,
		i8_subm = 4'd3,
		i8_add = 4'd4,
		i8_sub = 4'd5,
		i8_ldi = 4'd6,
		i8_ldm = 4'd7,
		i8_bf = 4'd8,
		i8_bb = 4'd9,
		i8_call = 4'd10,
		i8_stam = 4'd11,
		i8_orm = 4'd13, // 12 left free
		i8_andm = 4'd14,
		i8_prefix = 4'd15
	} op_i8_e;

	// i3 opcode sits in imm[7:4]
	typedef enum logic [3:0] {
		i3_shl = 4'd0,
		i3_shlo = 4'd1,
		i3_shr = 4'd2,
		i3_asr = 4'd3,
		i3_out = 4'd8,
		i3_prefix = 4'd15
	} op_i3_e;

	typedef enum logic [3:0] {
		i0_not = 4'd0,
		i0_ret = 4'd3,
		i0_nop = 4'd5
	} op_i0_e;

	typedef enum logic [1:0] {
		cond_zero = 2'd0,
		cond_neg = 2'd1,
		cond_always = 2'd2,
		cond_always_alt = 2'd3
	} cond_e;

	typedef enum logic [3:0] {
		alu_or,
		alu_and,
		alu_not,
		alu_add,
		alu_sub,
		alu_shl,
		alu_shlo,
		alu_shr,
		alu_asr,
		alu_pass_b
	} alu_op_e;

	typedef struct packed {
		logic [i_width-16:0] rsvd_hi; // bits 19..15
		cond_e cond;
		logic rsvd_lo; // was the field select
		logic [3:0] opcode;
		logic [7:0] imm;
	} instr_t;

	typedef struct packed {
		cond_e cond;
		alu_op_e alu_op;
		logic src_mem; // b from data memory
		logic wr_acc;
		logic wr_mem;
		logic branch_fwd;
		logic branch_back;
		logic call;
		logic ret;
		logic out_en;
		word_t imm;
	} ctrl_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		iadr_t adr;
	} imem_req_t;

	typedef struct packed {
		logic ack;
		instr_t dat;
	} imem_rsp_t;

	typedef logic [port_count-1:0][d_width-1:0] port_bank_t;

endpackage

/* pat_alu.sv */
module pat_alu (
	input pat_pkg::word_t i_a,
	input pat_pkg::word_t i_b,
	input pat_pkg::alu_op_e i_op,
	output pat_pkg::word_t o_y
);

	logic is_sub;
	logic [2:0] sh;
	pat_pkg::word_t b_mod;
	pat_pkg::word_t sum;

	// one adder, sub is a + ~b + 1
	assign is_sub = i_op == pat_pkg::alu_sub;
	assign b_mod = is_sub ? ~i_b : i_b;
	assign sum = i_a + b_mod + {{(pat_pkg::d_width-1){1'b0}}, is_sub};

	assign sh = i_b[2:0];

	always_comb
	begin
		case (i_op)
			pat_pkg::alu_or: o_y = i_a | i_b;
			pat_pkg::alu_and: o_y = i_a & i_b;
			pat_pkg::alu_not: o_y = ~i_a;
			pat_pkg::alu_add, pat_pkg::alu_sub: o_y = sum;
			pat_pkg::alu_shl: o_y = i_a << sh;
			pat_pkg::alu_shlo: o_y = ~(~i_a << sh); // ones come in at bit 0
			pat_pkg::alu_shr: o_y = i_a >> sh;
			pat_pkg::alu_asr: o_y = $signed(i_a) >>> sh;
			default: o_y = i_b; // pass_b
		endcase
	end

endmodule

/* pat_data_mem.sv */
module pat_data_mem #(
	parameter int dmem_adr_width = 7
) (
	input logic clk,
	input logic [dmem_adr_width-1:0] i_rd_adr,
	input logic [dmem_adr_width-1:0] i_wr_adr,
	input logic i_wr_en,
	input pat_pkg::word_t i_wr_data,
	output pat_pkg::word_t o_rd_data
);

	pat_pkg::word_t mem [2**dmem_adr_width];

	assign o_rd_data = mem[i_rd_adr]; // async read

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_adr] <= i_wr_data;
	end

endmodule

/* pat_fetch.sv */
module pat_fetch (
	input logic clk,
	input logic reset,
	input pat_pkg::iadr_t i_pc,
	input logic i_done,
	input pat_pkg::imem_rsp_t i_imem_rsp,
	output pat_pkg::imem_req_t o_imem_req,
	output pat_pkg::instr_t o_instr,
	output logic o_valid
);

	typedef enum logic {st_req, st_busy} state_e;

	state_e state;
	logic req_q; // drives cyc and stb
	logic accept;

	assign accept = (state == st_req) && req_q && i_imem_rsp.ack;

	assign o_imem_req.cyc = req_q;
	assign o_imem_req.stb = req_q;
	assign o_imem_req.adr = i_pc; // pc holds still until execute commits

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_req;
			req_q <= 1'b0;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= 1'b0;
			case (state)
				st_req:
				begin
					req_q <= 1'b1; // first request after reset
					if (accept)
					begin
						req_q <= 1'b0;
						o_valid <= 1'b1;
						state <= st_busy;
					end
				end
				st_busy:
				begin
					if (i_done)
					begin
						req_q <= 1'b1; // next pc is valid from here
						state <= st_req;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			o_instr <= i_imem_rsp.dat;
	end

	// slave may stretch the cycle, adr must not move under it
	assert property (@(posedge clk) disable iff (reset)
		o_imem_req.stb && !i_imem_rsp.ack |=> $stable(o_imem_req.adr))
	else $error("imem adr changed while waiting for ack");

endmodule

/* pat_decode.sv */
module pat_decode (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_t i_instr,
	input logic i_valid,
	output pat_pkg::ctrl_t o_ctrl,
	output logic o_valid
);

	pat_pkg::ctrl_t next_ctrl;
	logic is_i8;
	logic is_i3;
	logic [3:0] op_i3;
	logic [3:0] op_i0;

	assign op_i3 = i_instr.imm[7:4];
	assign op_i0 = i_instr.imm[3:0];
	assign is_i8 = i_instr.opcode != pat_pkg::i8_prefix;
	assign is_i3 = !is_i8 && (op_i3 != pat_pkg::i3_prefix);

	always_comb
	begin
		next_ctrl = '0; // no effect unless an opcode below matches
		next_ctrl.cond = i_instr.cond;
		next_ctrl.alu_op = pat_pkg::alu_pass_b;
		next_ctrl.imm = is_i8 ? i_instr.imm : {5'b0, i_instr.imm[2:0]};
		if (is_i8)
		begin
			case (pat_pkg::op_i8_e'(i_instr.opcode))
				pat_pkg::i8_or: next_ctrl.alu_op = pat_pkg::alu_or;
				pat_pkg::i8_and: next_ctrl.alu_op = pat_pkg::alu_and;
				pat_pkg::i8_orm: next_ctrl.alu_op = pat_pkg::alu_or;
				pat_pkg::i8_andm: next_ctrl.alu_op = pat_pkg::alu_and;
				pat_pkg::i8_add, pat_pkg::i8_addm: next_ctrl.alu_op = pat_pkg::alu_add;
				pat_pkg::i8_sub, pat_pkg::i8_subm: next_ctrl.alu_op = pat_pkg::alu_sub;
				default: next_ctrl.alu_op = pat_pkg::alu_pass_b; // ldi, ldm
			endcase
			case (pat_pkg::op_i8_e'(i_instr.opcode))
				pat_pkg::i8_or, pat_pkg::i8_and, pat_pkg::i8_add, pat_pkg::i8_sub,
				pat_pkg::i8_ldi:
					next_ctrl.wr_acc = 1'b1;
				pat_pkg::i8_addm, pat_pkg::i8_subm, pat_pkg::i8_orm, pat_pkg::i8_andm,
				pat_pkg::i8_ldm:
				begin
					next_ctrl.wr_acc = 1'b1;
					next_ctrl.src_mem = 1'b1;
				end
				pat_pkg::i8_stam: next_ctrl.wr_mem = 1'b1;
				pat_pkg::i8_bf: next_ctrl.branch_fwd = 1'b1;
				pat_pkg::i8_bb: next_ctrl.branch_back = 1'b1;
				pat_pkg::i8_call: next_ctrl.call = 1'b1;
				default: ; // 12 was setsp
			endcase
		end
		else if (is_i3)
		begin
			case (pat_pkg::op_i3_e'(op_i3))
				pat_pkg::i3_shl: next_ctrl.alu_op = pat_pkg::alu_shl;
				pat_pkg::i3_shlo: next_ctrl.alu_op = pat_pkg::alu_shlo;
				pat_pkg::i3_shr: next_ctrl.alu_op = pat_pkg::alu_shr;
				pat_pkg::i3_asr: next_ctrl.alu_op = pat_pkg::alu_asr;
				default: next_ctrl.alu_op = pat_pkg::alu_pass_b;
			endcase
			next_ctrl.wr_acc = op_i3[3:2] == 2'b00; // the four shifts
			next_ctrl.out_en = op_i3 == pat_pkg::i3_out;
		end
		else
		begin
			case (pat_pkg::op_i0_e'(op_i0))
				pat_pkg::i0_not:
				begin
					next_ctrl.alu_op = pat_pkg::alu_not;
					next_ctrl.wr_acc = 1'b1;
				end
				pat_pkg::i0_ret: next_ctrl.ret = 1'b1;
				default: ; // nop and anything unknown
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge clk)
	begin
		if (i_valid)
			o_ctrl <= next_ctrl;
	end

endmodule

/* pat_pc.sv */
module pat_pc #(
	parameter int call_depth = 8
) (
	input logic clk,
	input logic reset,
	input pat_pkg::ctrl_t i_ctrl,
	input logic i_valid,
	input logic i_take,
	output pat_pkg::iadr_t o_pc
);

	localparam int depth_width = $clog2(call_depth + 1);
	localparam int idx_width = $clog2(call_depth);
	localparam int ext_width = pat_pkg::i_adr_width - pat_pkg::d_width;

	pat_pkg::iadr_t stack [call_depth];
	logic [depth_width-1:0] depth; // entries in use
	logic [depth_width-1:0] top;
	pat_pkg::iadr_t pc_inc;
	pat_pkg::iadr_t pc_fwd;
	pat_pkg::iadr_t pc_back;
	logic push;
	logic pop;

	assign pc_inc = o_pc + 1'b1;
	assign pc_fwd = o_pc + {{ext_width{i_ctrl.imm[pat_pkg::d_width-1]}}, i_ctrl.imm};
	assign pc_back = o_pc - {{ext_width{1'b0}}, i_ctrl.imm};
	assign top = depth - 1'b1;

	assign push = i_valid && i_take && i_ctrl.call;
	assign pop = i_valid && i_take && i_ctrl.ret;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= '0;
			depth <= '0;
		end
		else if (i_valid)
		begin
			if (pop)
			begin
				o_pc <= stack[top[idx_width-1:0]];
				depth <= top;
			end
			else if (i_take && (i_ctrl.branch_fwd || i_ctrl.call))
				o_pc <= pc_fwd;
			else if (i_take && i_ctrl.branch_back)
				o_pc <= pc_back;
			else
				o_pc <= pc_inc;
			if (push)
				depth <= depth + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			stack[depth[idx_width-1:0]] <= pc_inc; // return lands after the call
	end

	assert property (@(posedge clk) disable iff (reset) push |-> depth < call_depth)
	else $error("call stack overflow");

	assert property (@(posedge clk) disable iff (reset) pop |-> depth != 0)
	else $error("return with empty call stack");

endmodule

/* pat_execute.sv */
module pat_execute #(
	parameter int dmem_adr_width = 7
) (
	input logic clk,
	input logic reset,
	input pat_pkg::ctrl_t i_ctrl,
	input logic i_valid,
	output logic o_take,
	output logic o_done,
	output pat_pkg::word_t o_acc,
	output pat_pkg::port_bank_t o_ports
);

	localparam int port_sel_width = $clog2(pat_pkg::port_count);

	logic z_flag;
	logic n_flag;
	logic cond_ok;
	logic mem_we;
	logic [dmem_adr_width-1:0] mem_adr;
	pat_pkg::word_t mem_rd;
	pat_pkg::word_t alu_b;
	pat_pkg::word_t alu_y;

	always_comb
	begin
		case (i_ctrl.cond)
			pat_pkg::cond_zero: cond_ok = z_flag;
			pat_pkg::cond_neg: cond_ok = n_flag;
			default: cond_ok = 1'b1; // always
		endcase
	end

	assign o_take = i_valid && cond_ok;
	assign o_done = i_valid; // fetch restarts once this commits

	assign mem_adr = i_ctrl.imm[dmem_adr_width-1:0];
	assign mem_we = o_take && i_ctrl.wr_mem; // stam
	assign alu_b = i_ctrl.src_mem ? mem_rd : i_ctrl.imm;

	pat_alu u_alu (
		.i_a(o_acc),
		.i_b(alu_b),
		.i_op(i_ctrl.alu_op),
		.o_y(alu_y)
	);

	pat_data_mem #(
		.dmem_adr_width(dmem_adr_width)
	) u_dmem (
		.clk(clk),
		.i_rd_adr(mem_adr),
		.i_wr_adr(mem_adr),
		.i_wr_en(mem_we),
		.i_wr_data(o_acc),
		.o_rd_data(mem_rd)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			z_flag <= 1'b1; // acc starts at zero
			n_flag <= 1'b0;
			o_ports <= '0;
		end
		else if (o_take)
		begin
			if (i_ctrl.wr_acc)
			begin
				o_acc <= alu_y;
				z_flag <= alu_y == '0;
				n_flag <= alu_y[pat_pkg::d_width-1];
			end
			if (i_ctrl.out_en)
				o_ports[i_ctrl.imm[port_sel_width-1:0]] <= o_acc;
		end
	end

endmodule

/* pat_top.sv */
module pat_top #(
	parameter int call_depth = 8,
	parameter int dmem_adr_width = 7
) (
	input logic clk,
	input logic reset,
	input pat_pkg::imem_rsp_t i_imem_rsp,
	output pat_pkg::imem_req_t o_imem_req,
	output pat_pkg::word_t o_acc,
	output pat_pkg::port_bank_t o_ports
);

	pat_pkg::iadr_t pc;
	pat_pkg::instr_t instr;
	pat_pkg::ctrl_t ctrl;
	logic instr_valid;
	logic ctrl_valid;
	logic take;
	logic done;

	pat_fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.i_pc(pc),
		.i_done(done),
		.i_imem_rsp(i_imem_rsp),
		.o_imem_req(o_imem_req),
		.o_instr(instr),
		.o_valid(instr_valid)
	);

	pat_decode u_decode (
		.clk(clk),
		.reset(reset),
		.i_instr(instr),
		.i_valid(instr_valid),
		.o_ctrl(ctrl),
		.o_valid(ctrl_valid)
	);

	pat_execute #(
		.dmem_adr_width(dmem_adr_width)
	) u_execute (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_valid(ctrl_valid),
		.o_take(take),
		.o_done(done),
		.o_acc(o_acc),
		.o_ports(o_ports)
	);

	pat_pc #(
		.call_depth(call_depth)
	) u_pc (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_valid(ctrl_valid),
		.i_take(take),
		.o_pc(pc)
	);

endmodule

/* tb_clock.sv */
module tb_clock #(
	parameter int period = 100,
	parameter int reset_cycles = 2,
	parameter int release_delay = 10
) (
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk = 1'b0;
		forever #(period / 2) o_clk = ~o_clk;
	end

	// reset drops a little after the rising edge, like every other input
	initial
	begin
		o_reset = 1'b1;
		repeat (reset_cycles) @(posedge o_clk);
		#release_delay;
		o_reset = 1'b0;
	end

endmodule

/* tb_pat.sv */
module tb_pat;

	localparam int drive_delay = 10;
	localparam int stb_timeout = 20;
	localparam int reset_timeout = 10;

	localparam logic [1:0] c_zero = 2'd0;
	localparam logic [1:0] c_neg = 2'd1;
	localparam logic [1:0] c_al = 2'd2;

	// i8 opcodes
	localparam logic [3:0] op_or = 4'd0;
	localparam logic [3:0] op_and = 4'd1;
	localparam logic [3:0] op_addm = 4'd2;
	localparam logic [3:0] op_subm = 4'd3;
	localparam logic [3:0] op_add = 4'd4;
	localparam logic [3:0] op_sub = 4'd5;
	localparam logic [3:0] op_ldi = 4'd6;
	localparam logic [3:0] op_ldm = 4'd7;
	localparam logic [3:0] op_bf = 4'd8;
	localparam logic [3:0] op_bb = 4'd9;
	localparam logic [3:0] op_call = 4'd10;
	localparam logic [3:0] op_stam = 4'd11;
	localparam logic [3:0] op_orm = 4'd13;
	localparam logic [3:0] op_andm = 4'd14;
	localparam logic [3:0] op_prefix = 4'd15;
	// i3 and i0 opcodes
	localparam logic [3:0] op_shl = 4'd0;
	localparam logic [3:0] op_shlo = 4'd1;
	localparam logic [3:0] op_shr = 4'd2;
	localparam logic [3:0] op_asr = 4'd3;
	localparam logic [3:0] op_out = 4'd8;
	localparam logic [3:0] op_not = 4'd0;
	localparam logic [3:0] op_ret = 4'd3;
	localparam logic [3:0] op_nop = 4'd5;

	logic clk;
	logic reset;
	pat_pkg::imem_rsp_t imem_rsp;
	pat_pkg::imem_req_t imem_req;
	pat_pkg::word_t acc;
	pat_pkg::port_bank_t ports;

	logic [19:0] prog [1024];
	string row_name [$];
	int row_adr [$];
	int row_acc [$];
	int final_ports [8];
	integer seed = 11;

	tb_clock u_clock (
		.o_clk(clk),
		.o_reset(reset)
	);

	pat_top #(
		.call_depth(8),
		.dmem_adr_width(7)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.i_imem_rsp(imem_rsp),
		.o_imem_req(imem_req),
		.o_acc(acc),
		.o_ports(ports)
	);

	// reserved bits left at zero
	function automatic logic [19:0] enc_i8(input logic [1:0] cond, input logic [3:0] op,
		input logic [7:0] imm);
		enc_i8 = {5'b0, cond, 1'b0, op, imm};
	endfunction

	function automatic logic [19:0] enc_i3(input logic [1:0] cond, input logic [3:0] op,
		input logic [2:0] imm);
		enc_i3 = enc_i8(cond, op_prefix, {op, 1'b0, imm});
	endfunction

	function automatic logic [19:0] enc_i0(input logic [1:0] cond, input logic [3:0] op);
		enc_i0 = enc_i8(cond, op_prefix, {op_prefix, op});
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	endtask

	// counts sampled cycles until a request shows up
	task automatic wait_for_stb(input string what, output int cycles);
		cycles = 0;
		while (!imem_req.stb)
		begin
			@(posedge clk);
			#drive_delay;
			cycles++;
			if (cycles > stb_timeout)
				report_timeout({"stb before ", what});
		end
	endtask

	task automatic add_row(input string name, input int adr, input int acc_exp);
		row_name.push_back(name);
		row_adr.push_back(adr);
		row_acc.push_back(acc_exp);
	endtask

	task automatic load_program();
		prog[0] = enc_i8(c_al, op_ldi, 8'h5a);
		prog[1] = enc_i8(c_al, op_or, 8'h81);
		prog[2] = enc_i8(c_al, op_and, 8'h0f);
		prog[3] = enc_i8(c_al, op_add, 8'hf8); // carry out dropped
		prog[4] = enc_i8(c_al, op_sub, 8'h05);
		prog[5] = enc_i0(c_al, op_not);
		prog[6] = enc_i3(c_al, op_shl, 3'd3);
		prog[7] = enc_i3(c_al, op_shlo, 3'd2);
		prog[8] = enc_i8(c_al, op_ldi, 8'h96);
		prog[9] = enc_i3(c_al, op_shr, 3'd1);
		prog[10] = enc_i8(c_al, op_ldi, 8'h90);
		prog[11] = enc_i3(c_al, op_asr, 3'd3);
		prog[12] = enc_i8(c_al, op_stam, 8'h10);
		prog[13] = enc_i8(c_al, op_ldi, 8'h33);
		prog[14] = enc_i8(c_al, op_stam, 8'h7f);
		prog[15] = enc_i8(c_al, op_ldm, 8'h10);
		prog[16] = enc_i8(c_al, op_addm, 8'h7f);
		prog[17] = enc_i8(c_al, op_subm, 8'h10);
		prog[18] = enc_i8(c_al, op_orm, 8'h10);
		prog[19] = enc_i8(c_al, op_andm, 8'h7f);
		prog[20] = enc_i3(c_al, op_out, 3'd1);
		prog[21] = enc_i8(c_al, op_sub, 8'h33); // acc to zero, z set
		prog[22] = enc_i8(c_zero, op_ldi, 8'h11);
		prog[23] = enc_i8(c_zero, op_ldi, 8'h22);
		prog[24] = enc_i8(c_al, op_sub, 8'h12);
		prog[25] = enc_i3(c_neg, op_out, 3'd2);
		prog[26] = enc_i8(c_zero, op_ldi, 8'h44);
		prog[27] = enc_i8(c_neg, op_bf, 8'h03);
		prog[28] = enc_i8(c_al, op_ldi, 8'hee); // jumped over
		prog[29] = enc_i8(c_al, op_ldi, 8'hee);
		prog[30] = enc_i8(c_zero, op_bf, 8'h05);
		prog[31] = enc_i8(c_al, op_ldi, 8'h7c);
		prog[32] = enc_i8(c_neg, op_bb, 8'h0a);
		prog[33] = enc_i8(c_al, op_call, 8'h07);
		prog[34] = enc_i3(c_al, op_out, 3'd7);
		prog[35] = enc_i8(c_al, op_bf, 8'h14);
		prog[40] = enc_i8(c_al, op_add, 8'h01); // outer subroutine
		prog[41] = enc_i8(c_al, op_call, 8'h05);
		prog[42] = enc_i0(c_al, op_ret);
		prog[46] = enc_i3(c_al, op_shl, 3'd1); // inner subroutine
		prog[47] = enc_i3(c_al, op_out, 3'd3);
		prog[48] = enc_i0(c_al, op_ret);
		prog[50] = enc_i8(c_al, op_ldi, 8'h00);
		prog[51] = enc_i8(c_neg, op_bb, 8'h03);
		prog[52] = enc_i0(c_al, op_nop);
		prog[53] = enc_i8(c_al, op_bf, 8'h0a);
		prog[55] = enc_i8(c_al, op_bb, 8'h05);
		prog[57] = enc_i8(c_al, op_bb, 8'h00); // parks here
		prog[63] = enc_i8(c_al, op_bf, 8'hfa); // -6
	endtask

	// each row is a fetch, acc is the value left by everything before it
	task automatic load_trace();
		add_row("reset", 0, 'h00);
		add_row("ldi", 1, 'h5a);
		add_row("or", 2, 'hdb);
		add_row("and", 3, 'h0b);
		add_row("add", 4, 'h03);
		add_row("sub", 5, 'hfe);
		add_row("not", 6, 'h01);
		add_row("shl", 7, 'h08);
		add_row("shlo", 8, 'h23);
		add_row("ldi_96", 9, 'h96);
		add_row("shr", 10, 'h4b);
		add_row("ldi_90", 11, 'h90);
		add_row("asr", 12, 'hf2);
		add_row("stam_10", 13, 'hf2);
		add_row("ldi_33", 14, 'h33);
		add_row("stam_7f", 15, 'h33);
		add_row("ldm", 16, 'hf2);
		add_row("addm", 17, 'h25);
		add_row("subm", 18, 'h33);
		add_row("orm", 19, 'hf3);
		add_row("andm", 20, 'h33);
		add_row("out_1", 21, 'h33);
		add_row("sub_to_zero", 22, 'h00);
		add_row("zero_taken", 23, 'h11);
		add_row("zero_skipped", 24, 'h11);
		add_row("sub_to_neg", 25, 'hff);
		add_row("neg_out", 26, 'hff);
		add_row("zero_skipped_2", 27, 'hff);
		add_row("bf_taken", 30, 'hff);
		add_row("bf_not_taken", 31, 'hff);
		add_row("ldi_7c", 32, 'h7c);
		add_row("bb_not_taken", 33, 'h7c);
		add_row("call", 40, 'h7c);
		add_row("add_in_call", 41, 'h7d);
		add_row("call_nested", 46, 'h7d);
		add_row("shl_in_call", 47, 'hfa);
		add_row("out_3", 48, 'hfa);
		add_row("ret_inner", 42, 'hfa);
		add_row("ret_outer", 34, 'hfa);
		add_row("out_7", 35, 'hfa);
		add_row("bf_far", 55, 'hfa);
		add_row("bb_taken", 50, 'hfa);
		add_row("ldi_00", 51, 'h00);
		add_row("bb_neg_skipped", 52, 'h00);
		add_row("nop", 53, 'h00);
		add_row("bf_fwd", 63, 'h00);
		add_row("bf_negative", 57, 'h00);
		final_ports = '{'h00, 'h33, 'hff, 'hfa, 'h00, 'h00, 'h00, 'hfa};
	endtask

	initial
	begin
		int gap;
		int delay;
		int n;
		imem_rsp = '0;
		load_program();
		load_trace();

		// no request while reset is high
		n = 0;
		@(posedge clk);
		while (reset)
		begin
			#drive_delay;
			check_value("reset cyc", 0, 32'(imem_req.cyc));
			check_value("reset stb", 0, 32'(imem_req.stb));
			n++;
			if (n > reset_timeout)
				report_timeout("reset release");
			@(posedge clk);
		end
		#drive_delay;

		for (int i = 0; i < row_name.size(); i++)
		begin
			wait_for_stb(row_name[i], gap);
			check_value({row_name[i], " gap"}, (i == 0) ? 0 : 2, gap);
			check_value({row_name[i], " cyc"}, 1, 32'(imem_req.cyc));
			check_value({row_name[i], " adr"}, row_adr[i], 32'(imem_req.adr));
			check_value({row_name[i], " acc"}, row_acc[i], 32'(acc));
			delay = $random(seed) & 3; // wait states before ack
			repeat (delay)
			begin
				@(posedge clk);
				#drive_delay;
			end
			imem_rsp.ack = 1'b1;
			imem_rsp.dat = prog[imem_req.adr];
			@(posedge clk); // ack sampled here
			#drive_delay;
			imem_rsp = '0;
		end

		wait_for_stb("end", gap);
		check_value("end gap", 2, gap);
		check_value("end cyc", 1, 32'(imem_req.cyc));
		check_value("end adr", 57, 32'(imem_req.adr));
		for (int p = 0; p < 8; p++)
			check_value($sformatf("port_%0d", p), final_ports[p], 32'(ports[p]));

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* list.f */
pat_pkg.sv
pat_alu.sv
pat_data_mem.sv
pat_fetch.sv
pat_decode.sv
pat_pc.sv
pat_execute.sv
pat_top.sv
tb_clock.sv
tb_pat.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_pat -Mdir obj_dir -o sim_tb_pat

# the simulator exits non-zero on a failure, the log decides
./obj_dir/sim_tb_pat > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
